// File: common/sm3_cfg.svh
/*
 * Build-time constants of the SM3 core.
 * Included by the package and by RTL files that size counters or windows.
 */
`ifndef SM3_CFG_SVH
`define SM3_CFG_SVH

// word and block geometry
`define SM3_WORD_W 32
`define SM3_BLOCK_WORDS 16

// rounds per compression
`define SM3_ROUNDS 64
`define SM3_EARLY_ROUNDS 16

// round constants before rotation
`define SM3_T_EARLY 32'h79cc4519
`define SM3_T_LATE 32'h7a879d8a

`endif

// File: common/sm3_pkg.sv
/*
 * Shared types and constants of the SM3 core.
 * Referenced by scoped names from every RTL file.
 */
`include "sm3_cfg.svh"

package sm3_pkg;

	typedef logic [`SM3_WORD_W-1:0] sm3_word_t;

	// A in word 7, H in word 0
	typedef sm3_word_t [7:0] sm3_digest_t;

	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		ROUNDS,
		FINISH
	} sm3_ctrl_state_t;

	localparam sm3_digest_t SM3_IV = {
		32'h7380166f, 32'h4914b2b9, 32'h172442d7, 32'hda8a0600,
		32'ha96f30bc, 32'h163138aa, 32'he38dee4d, 32'hb0fb0e4e
	};

	// left rotate, n between 1 and word width - 1
	function automatic sm3_word_t rotl(input sm3_word_t x, input int n);
		return (x << n) | (x >> (`SM3_WORD_W - n));
	endfunction

endpackage

// File: rtl/sm3_ctrl.sv
/*
 * Block sequencer of the SM3 core.
 * Counts the sixteen host words, then runs 64 rounds and one finish cycle.
 */
`timescale 1ns/10ps
`include "sm3_cfg.svh"

module sm3_ctrl
(
	input  logic clk_in,
	input  logic reset_n_in,
	input  logic word_valid,
	input  logic first_block,
	output logic load_en,
	output logic block_start,
	output logic round_en,
	output logic late_rounds,
	output logic finish,
	output logic use_iv,
	output logic busy,
	output logic done
);

	sm3_pkg::sm3_ctrl_state_t state;
	sm3_pkg::sm3_ctrl_state_t state_next;
	logic [3:0] word_cnt;
	logic [5:0] round_cnt;
	logic       accept_open;
	logic       last_word;
	logic       last_round;

	// host words only before the rounds start
	assign accept_open = (state == sm3_pkg::IDLE) || (state == sm3_pkg::LOAD);
	assign load_en = word_valid && accept_open;
	assign last_word = (word_cnt == 4'(`SM3_BLOCK_WORDS - 1));
	assign block_start = load_en && last_word;

	assign round_en = (state == sm3_pkg::ROUNDS);
	assign last_round = (round_cnt == 6'(`SM3_ROUNDS - 1));
	assign late_rounds = round_en && (round_cnt >= 6'(`SM3_EARLY_ROUNDS));
	assign finish = (state == sm3_pkg::FINISH);
	assign busy = (state != sm3_pkg::IDLE);

	always_comb
	begin
		state_next = state;
		case (state)
			sm3_pkg::IDLE:
				if (load_en)
					state_next = sm3_pkg::LOAD;
			sm3_pkg::LOAD:
				if (block_start)
					state_next = sm3_pkg::ROUNDS;
			sm3_pkg::ROUNDS:
				if (last_round)
					state_next = sm3_pkg::FINISH;
			default:
				state_next = sm3_pkg::IDLE;
		endcase
	end

	// counters wrap back to zero at the end of their phase
	always_ff @(posedge clk_in)
	begin
		if (!reset_n_in)
		begin
			state <= sm3_pkg::IDLE;
			word_cnt <= '0;
			round_cnt <= '0;
			use_iv <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			done <= finish;
			if (load_en)
				word_cnt <= word_cnt + 4'd1;
			if (round_en)
				round_cnt <= round_cnt + 6'd1;
			if (load_en && (state == sm3_pkg::IDLE))
				use_iv <= first_block;
		end
	end

	// ********************
	// checks
	a_no_word_in_rounds: assert property (@(posedge clk_in) disable iff (!reset_n_in)
		!accept_open |-> !word_valid)
		else $error("word offered while block is compressing");

	a_cnt_idle_zero: assert property (@(posedge clk_in) disable iff (!reset_n_in)
		(state == sm3_pkg::IDLE) |-> (word_cnt == 4'd0) && (round_cnt == 6'd0))
		else $error("word or round counter not back at zero between blocks");

endmodule

// File: expansion/sm3_msg_expansion.sv
/*
 * SM3 message expansion over a sixteen-word sliding window.
 * Host words shift in on load_en, expanded words on round_en.
 */
`timescale 1ns/10ps
`include "sm3_cfg.svh"

module sm3_msg_expansion
(
	input  logic               clk_in,
	input  logic               reset_n_in,
	input  sm3_pkg::sm3_word_t word,
	input  logic               load_en,
	input  logic               round_en,
	output sm3_pkg::sm3_word_t w,
	output sm3_pkg::sm3_word_t w_prime
);

	sm3_pkg::sm3_word_t win [`SM3_BLOCK_WORDS];
	sm3_pkg::sm3_word_t p1_in;
	sm3_pkg::sm3_word_t p1_out;
	sm3_pkg::sm3_word_t w_next;

	// win[0] is W[j] during round j
	assign w = win[0];
	assign w_prime = win[0] ^ win[4];

	// W[j+16] from W[j], W[j+3], W[j+7], W[j+10], W[j+13]
	assign p1_in = win[0] ^ win[7] ^ sm3_pkg::rotl(win[13], 15);
	assign p1_out = p1_in ^ sm3_pkg::rotl(p1_in, 15) ^ sm3_pkg::rotl(p1_in, 23);
	assign w_next = p1_out ^ sm3_pkg::rotl(win[3], 7) ^ win[10];

	always_ff @(posedge clk_in)
	begin
		if (load_en || round_en)
		begin
			for (int i = 0; i < `SM3_BLOCK_WORDS - 1; i++)
			begin
				win[i] <= win[i + 1];
			end
			win[`SM3_BLOCK_WORDS - 1] <= load_en ? word : w_next;
		end
	end

	// controller must never load while rounds run
	a_load_round_excl: assert property (@(posedge clk_in) disable iff (!reset_n_in)
		!(load_en && round_en))
		else $error("window shifted by load and round at once");

endmodule

// File: compression/sm3_round_const.sv
/*
 * Round constant source, T rotated left by the round index.
 * The rotated value is kept in a register and stepped once per round.
 */
`timescale 1ns/10ps

module sm3_round_const #(
	parameter sm3_pkg::sm3_word_t T_EARLY = '0,
	parameter sm3_pkg::sm3_word_t T_LATE = '0
)
(
	input  logic               clk_in,
	input  logic               reset_n_in,
	input  logic               block_start,
	input  logic               round_en,
	input  logic               late_rounds,
	output sm3_pkg::sm3_word_t t_rot
);

	sm3_pkg::sm3_word_t t_reg;
	logic               late_q;
	logic               late_rise;

	// first late round uses T_late <<< 16
	assign late_rise = late_rounds && !late_q;
	assign t_rot = late_rise ? sm3_pkg::rotl(T_LATE, 16) : t_reg;

	always_ff @(posedge clk_in)
	begin
		if (!reset_n_in)
			late_q <= 1'b0;
		else
			late_q <= late_rounds;
	end

	always_ff @(posedge clk_in)
	begin
		if (block_start)
			t_reg <= T_EARLY;
		else if (round_en)
			t_reg <= sm3_pkg::rotl(t_rot, 1);
	end

endmodule

// File: compression/sm3_compress.sv
/*
 * SM3 compression function, one round per round_en.
 * Holds the A-H working registers and the chaining value,
 * which is also the digest output.
 */
`timescale 1ns/10ps

module sm3_compress
(
	input  logic                 clk_in,
	input  logic                 reset_n_in,
	input  logic                 block_start,
	input  logic                 use_iv,
	input  logic                 round_en,
	input  logic                 late_rounds,
	input  logic                 finish,
	input  sm3_pkg::sm3_word_t   w,
	input  sm3_pkg::sm3_word_t   w_prime,
	input  sm3_pkg::sm3_word_t   t_rot,
	output sm3_pkg::sm3_digest_t digest
);

	sm3_pkg::sm3_word_t a;
	sm3_pkg::sm3_word_t b;
	sm3_pkg::sm3_word_t c;
	sm3_pkg::sm3_word_t d;
	sm3_pkg::sm3_word_t e;
	sm3_pkg::sm3_word_t f;
	sm3_pkg::sm3_word_t g;
	sm3_pkg::sm3_word_t h;
	sm3_pkg::sm3_word_t a_rot12;
	sm3_pkg::sm3_word_t ss1;
	sm3_pkg::sm3_word_t ss2;
	sm3_pkg::sm3_word_t ff;
	sm3_pkg::sm3_word_t gg;
	sm3_pkg::sm3_word_t tt1;
	sm3_pkg::sm3_word_t tt2;
	sm3_pkg::sm3_digest_t chain;

	// first block of a message starts from the IV
	assign chain = use_iv ? sm3_pkg::SM3_IV : digest;

	// ********************
	// round function
	assign a_rot12 = sm3_pkg::rotl(a, 12);
	assign ss1 = sm3_pkg::rotl(a_rot12 + e + t_rot, 7);
	assign ss2 = ss1 ^ a_rot12;

	// majority and choose in rounds 16..63
	assign ff = late_rounds ? ((a & b) | (a & c) | (b & c)) : (a ^ b ^ c);
	assign gg = late_rounds ? ((e & f) | (~e & g)) : (e ^ f ^ g);

	assign tt1 = ff + d + ss2 + w_prime;
	assign tt2 = gg + h + ss1 + w;

	always_ff @(posedge clk_in)
	begin
		if (block_start)
		begin
			{a, b, c, d, e, f, g, h} <= chain;
		end
		else if (round_en)
		begin
			a <= tt1;
			b <= a;
			c <= sm3_pkg::rotl(b, 9);
			d <= c;
			// P0
			e <= tt2 ^ sm3_pkg::rotl(tt2, 9) ^ sm3_pkg::rotl(tt2, 17);
			f <= e;
			g <= sm3_pkg::rotl(f, 19);
			h <= g;
		end
	end

	// ********************
	// feed-forward
	always_ff @(posedge clk_in)
	begin
		if (!reset_n_in)
			digest <= '0;
		else if (finish)
			digest <= chain ^ {a, b, c, d, e, f, g, h};
	end

	// finish comes one cycle after the last round
	a_finish_not_round: assert property (@(posedge clk_in) disable iff (!reset_n_in)
		finish |-> !round_en)
		else $error("finish raised during a round");

endmodule

// File: rtl/sm3_core.sv
/*
 * SM3 hash core, one pre-padded 512-bit block at a time.
 * Feed sixteen words with word_valid, flag the first block of a message,
 * and read digest when done pulses.
 */
`timescale 1ns/10ps
`include "sm3_cfg.svh"

module sm3_core
(
	input  logic                clk_in,
	input  logic                reset_n_in,
	input  sm3_pkg::sm3_word_t  word,
	input  logic                word_valid,
	input  logic                first_block,
	output logic                busy,
	output logic                done,
	output sm3_pkg::sm3_digest_t digest
);

	logic load_en;
	logic block_start;
	logic round_en;
	logic late_rounds;
	logic finish;
	logic use_iv;
	sm3_pkg::sm3_word_t w;
	sm3_pkg::sm3_word_t w_prime;
	sm3_pkg::sm3_word_t t_rot;

	// ********************
	// sequencing
	sm3_ctrl sm3_ctrl_inst
	(
		.clk_in      (clk_in),
		.reset_n_in  (reset_n_in),
		.word_valid  (word_valid),
		.first_block (first_block),
		.load_en     (load_en),
		.block_start (block_start),
		.round_en    (round_en),
		.late_rounds (late_rounds),
		.finish      (finish),
		.use_iv      (use_iv),
		.busy        (busy),
		.done        (done)
	);

	// ********************
	// datapath
	sm3_msg_expansion sm3_msg_expansion_inst
	(
		.clk_in     (clk_in),
		.reset_n_in (reset_n_in),
		.word       (word),
		.load_en    (load_en),
		.round_en   (round_en),
		.w          (w),
		.w_prime    (w_prime)
	);

	sm3_round_const #(
		.T_EARLY (`SM3_T_EARLY),
		.T_LATE  (`SM3_T_LATE)
	) sm3_round_const_inst
	(
		.clk_in      (clk_in),
		.reset_n_in  (reset_n_in),
		.block_start (block_start),
		.round_en    (round_en),
		.late_rounds (late_rounds),
		.t_rot       (t_rot)
	);

	sm3_compress sm3_compress_inst
	(
		.clk_in      (clk_in),
		.reset_n_in  (reset_n_in),
		.block_start (block_start),
		.use_iv      (use_iv),
		.round_en    (round_en),
		.late_rounds (late_rounds),
		.finish      (finish),
		.w           (w),
		.w_prime     (w_prime),
		.t_rot       (t_rot),
		.digest      (digest)
	);

endmodule

// File: testbench/sm3_core_tb.sv
/*
 * Testbench for the SM3 core.
 * Applies a table of pre-padded blocks one word at a time with random gaps,
 * then checks busy, the done latency and the digest of each message.
 */
`timescale 1ns/10ps
`include "sm3_cfg.svh"

module sm3_core_tb;

	localparam int NUM_BLOCKS = 4;
	localparam int CYCLE_LIMIT = 4 * (NUM_BLOCKS * 120);
	localparam int DONE_LATENCY = `SM3_ROUNDS + 1;

	logic                 clk_in;
	logic                 reset_n_in;
	sm3_pkg::sm3_word_t   word;
	logic                 word_valid;
	logic                 first_block;
	logic                 busy;
	logic                 done;
	sm3_pkg::sm3_digest_t digest;

	logic [511:0] block_tab [NUM_BLOCKS];
	logic         first_tab [NUM_BLOCKS];
	logic         check_tab [NUM_BLOCKS];
	logic [255:0] expect_tab [NUM_BLOCKS];
	string        name_tab [NUM_BLOCKS];
	int           cycle_cnt;

	sm3_core sm3_core_inst
	(
		.clk_in      (clk_in),
		.reset_n_in  (reset_n_in),
		.word        (word),
		.word_valid  (word_valid),
		.first_block (first_block),
		.busy        (busy),
		.done        (done),
		.digest      (digest)
	);

	initial
		clk_in = 1'b0;

	always #2 clk_in = ~clk_in;

	// ********************
	// reporting
	task automatic report_mismatch(input string test_name, input string exp_str,
		input string act_str);
		$display("[FAIL] %s expected %s actual %s", test_name, exp_str, act_str);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic abort_with_error(input string what);
		$display("[ERROR] %s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	always @(posedge clk_in)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT)
			abort_with_error($sformatf("no result after %0d cycles, run stopped", cycle_cnt));
	end

	// ********************
	// vectors
	task automatic load_vectors();
		// "abc", one padded block
		block_tab[0] = {32'h61626380, 448'h0, 32'h00000018};
		first_tab[0] = 1'b1;
		check_tab[0] = 1'b1;
		expect_tab[0] = 256'h66c7f0f462eeedd9d1f2d46bdc10e4e24167c4875cf2f7a2297da02b8f4ba8e0;
		name_tab[0] = "abc";
		// "abcd" x16, two chained blocks
		block_tab[1] = {16{32'h61626364}};
		first_tab[1] = 1'b1;
		check_tab[1] = 1'b0;
		expect_tab[1] = '0;
		name_tab[1] = "abcd_x16_blk1";
		block_tab[2] = {32'h80000000, 448'h0, 32'h00000200};
		first_tab[2] = 1'b0;
		check_tab[2] = 1'b1;
		expect_tab[2] = 256'hdebe9ff92275b8a138604889c18e5a4d6fdb70e5387e5765293dcba39c0c5732;
		name_tab[2] = "abcd_x16_blk2";
		// restart from the IV
		block_tab[3] = block_tab[0];
		first_tab[3] = 1'b1;
		check_tab[3] = 1'b1;
		expect_tab[3] = expect_tab[0];
		name_tab[3] = "abc_again";
	endtask

	task automatic check_held(input string test_name, input logic [255:0] held);
		assert (digest == held)
		else report_mismatch({test_name, " digest_hold"}, $sformatf("%h", held),
			$sformatf("%h", digest));
	endtask

	// one block, sampled 1 ns after each rising edge
	task automatic run_block(input int idx);
		int           gap;
		int           k;
		int           wait_cycles;
		logic [255:0] held;
		string        tname;
		tname = name_tab[idx];
		held = digest;
		assert (!busy && !done)
		else report_mismatch({tname, " idle"}, "busy=0 done=0",
			$sformatf("busy=%0b done=%0b", busy, done));
		for (k = 0; k < `SM3_BLOCK_WORDS; k++)
		begin
			gap = $urandom_range(2, 0);
			repeat (gap)
			begin
				@(posedge clk_in);
				#1;
				check_held(tname, held);
			end
			word = block_tab[idx][511 - 32 * k -: 32];
			word_valid = 1'b1;
			first_block = first_tab[idx];
			@(posedge clk_in);
			#1;
			word_valid = 1'b0;
			assert (busy)
			else report_mismatch({tname, $sformatf(" busy_word%0d", k)}, "1", "0");
			check_held(tname, held);
		end
		// 16th word was taken on the last edge
		wait_cycles = 0;
		while (!done)
		begin
			assert (busy)
			else report_mismatch({tname, " busy_rounds"}, "1", "0");
			check_held(tname, held);
			@(posedge clk_in);
			#1;
			wait_cycles++;
		end
		assert (wait_cycles == DONE_LATENCY)
		else report_mismatch({tname, " done_latency"}, $sformatf("%0d", DONE_LATENCY),
			$sformatf("%0d", wait_cycles));
		assert (!busy)
		else report_mismatch({tname, " busy_at_done"}, "0", "1");
		if (check_tab[idx])
		begin
			assert (digest == expect_tab[idx])
			else report_mismatch({tname, " digest"}, $sformatf("%h", expect_tab[idx]),
				$sformatf("%h", digest));
		end
		held = digest;
		@(posedge clk_in);
		#1;
		assert (!done)
		else report_mismatch({tname, " done_pulse"}, "0", "1");
		check_held(tname, held);
	endtask

	// ********************
	// main sequence
	initial
	begin
		void'($urandom(33));
		cycle_cnt = 0;
		reset_n_in = 1'b0;
		word = '0;
		word_valid = 1'b0;
		first_block = 1'b0;
		load_vectors();
		repeat (4) @(posedge clk_in);
		#1;
		reset_n_in = 1'b1;
		assert (!busy && !done && digest == '0)
		else report_mismatch("reset", "busy=0 done=0 digest=0",
			$sformatf("busy=%0b done=%0b digest=%h", busy, done, digest));
		for (int b = 0; b < NUM_BLOCKS; b++)
		begin
			run_block(b);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: sm3_core.f
+incdir+common
common/sm3_pkg.sv
rtl/sm3_ctrl.sv
expansion/sm3_msg_expansion.sv
compression/sm3_round_const.sv
compression/sm3_compress.sv
rtl/sm3_core.sv
testbench/sm3_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the SM3 core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f sm3_core.f --top-module sm3_core_tb -o sm3_core_sim || exit 1

./obj_dir/sm3_core_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
